// ==== logic/cabs_pkg.sv ====
// Complex magnitude detector definitions
`default_nettype none

package cabs_pkg;

  ////////////////////
  // sizes

  // channels per input beat
  localparam int NUM_CHANNELS = 4;

  // one complex sample, real and imaginary halves
  localparam int CHANNEL_WIDTH = 32;
  localparam int WORD_WIDTH = CHANNEL_WIDTH / 2;

  // result is at most 18 bits, zero-extended
  localparam int MAG_WIDTH = 32;

  localparam int COUNT_WIDTH = $clog2(NUM_CHANNELS);
  localparam logic [COUNT_WIDTH-1:0] LAST_CHANNEL = COUNT_WIDTH'(NUM_CHANNELS - 1);

  // enabled cycles from operand to magnitude
  localparam int CABS_DELAY = 2;

  ////////////////////
  // payload types

  typedef struct packed {
    logic signed [WORD_WIDTH-1:0] im;
    logic signed [WORD_WIDTH-1:0] re;
  } sample_t;

  // channel 0 sits in the low bits
  typedef sample_t [NUM_CHANNELS-1:0] beat_t;

  typedef logic [NUM_CHANNELS-1:0][MAG_WIDTH-1:0] mag_vec_t;

  // serializer output
  typedef struct packed {
    beat_t    data;
    mag_vec_t mag;
  } cabs_beat_t;

  // detector output
  typedef struct packed {
    beat_t                  data;
    mag_vec_t               mag;
    logic [COUNT_WIDTH-1:0] peak_idx;
    logic [MAG_WIDTH-1:0]   peak_mag;
  } detect_t;

endpackage

`default_nettype wire

// ==== logic/channel_counter.sv ====
// Saturating channel counter
`default_nettype none

module channel_counter (
  input  wire                              clk,
  input  wire                              reset,
  input  wire                              clear,
  input  wire                              enable,
  output logic [cabs_pkg::COUNT_WIDTH-1:0] count
);

  // clear wins over enable, count parks on the last channel
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      count <= '0;
    end else if (enable && (count != cabs_pkg::LAST_CHANNEL)) begin
      count <= count + 1'b1;
    end
  end

  ////////////////////
  // checks

  a_count_range: assert property (
    @(posedge clk) disable iff (reset)
    count <= cabs_pkg::LAST_CHANNEL
  ) else $error("channel count beyond last channel");

endmodule

`default_nettype wire

// ==== logic/delay_line.sv ====
// Enabled payload delay line
`default_nettype none

module delay_line #(
  parameter type payload_t = logic,
  parameter int  DEPTH = 2
) (
  input  wire           clk,
  input  wire           enable,
  input  wire payload_t din,
  output payload_t      dout
);

  // stage 0 is nearest the input
  payload_t stages [DEPTH];

  always_ff @(posedge clk) begin
    if (enable) begin
      stages[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  assign dout = stages[DEPTH-1];

endmodule

`default_nettype wire

// ==== logic/cabs_magnitude.sv ====
// Approximate complex magnitude
`default_nettype none

module cabs_magnitude (
  input  wire                            clk,
  input  wire                            enable,
  input  wire cabs_pkg::sample_t         sample,
  output logic [cabs_pkg::MAG_WIDTH-1:0] mag
);

  // one extra bit so that -32768 folds to +32768
  logic signed [cabs_pkg::WORD_WIDTH:0] re_ext;
  logic signed [cabs_pkg::WORD_WIDTH:0] im_ext;
  logic [cabs_pkg::WORD_WIDTH:0]        abs_re;
  logic [cabs_pkg::WORD_WIDTH:0]        abs_im;

  // stage one registers
  logic [cabs_pkg::WORD_WIDTH:0]        big_q;
  logic [cabs_pkg::WORD_WIDTH:0]        small_q;

  // max + min/2 needs one bit more than the operands
  logic [cabs_pkg::WORD_WIDTH+1:0]      sum;

  ////////////////////
  // stage one

  assign re_ext = sample.re;
  assign im_ext = sample.im;

  assign abs_re = re_ext[cabs_pkg::WORD_WIDTH] ? -re_ext : re_ext;
  assign abs_im = im_ext[cabs_pkg::WORD_WIDTH] ? -im_ext : im_ext;

  always_ff @(posedge clk) begin
    if (enable) begin
      if (abs_re >= abs_im) begin
        big_q   <= abs_re;
        small_q <= abs_im;
      end else begin
        big_q   <= abs_im;
        small_q <= abs_re;
      end
    end
  end

  ////////////////////
  // stage two

  // half of the smaller, rounded down
  assign sum = {1'b0, big_q} + {2'b00, small_q[cabs_pkg::WORD_WIDTH:1]};

  always_ff @(posedge clk) begin
    if (enable) begin
      mag <= {{(cabs_pkg::MAG_WIDTH - cabs_pkg::WORD_WIDTH - 2){1'b0}}, sum};
    end
  end

endmodule

`default_nettype wire

// ==== logic/cabs_serial.sv ====
// Channel serializer around the magnitude unit
`default_nettype none

module cabs_serial (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        s_valid,
  output logic                       s_ready,
  input  wire cabs_pkg::beat_t       s_data,
  output logic                       m_valid,
  input  wire                        m_ready,
  output cabs_pkg::cabs_beat_t       m_data
);

  logic                              stall;
  logic                              enable;
  logic                              last;
  logic                              s_frame;
  logic                              out_free;

  logic [cabs_pkg::COUNT_WIDTH-1:0]  count;
  logic [cabs_pkg::COUNT_WIDTH-1:0]  count_out;
  logic                              last_out;
  logic                              last_out_d;

  cabs_pkg::sample_t                 cur_sample;
  logic [cabs_pkg::MAG_WIDTH-1:0]    mag;
  cabs_pkg::mag_vec_t                mag_gather;
  cabs_pkg::beat_t                   data_out;

  // set once the first beat is taken, masks stale flags in the delay line
  logic                              armed;
  // gathered magnitudes and delayed beat are complete
  logic                              result_ready;

  ////////////////////
  // input side

  // hold everything while a finished result queues behind a full output
  assign stall    = result_ready & m_valid;
  assign enable   = s_valid & ~stall;
  assign last     = (count == cabs_pkg::LAST_CHANNEL);
  assign s_ready  = ~stall & last;
  assign s_frame  = s_valid & s_ready;

  channel_counter i_counter (
    .clk    (clk),
    .reset  (reset),
    .clear  (s_frame),
    .enable (enable),
    .count  (count)
  );

  assign cur_sample = s_data[count];

  cabs_magnitude i_magnitude (
    .clk    (clk),
    .enable (enable),
    .sample (cur_sample),
    .mag    (mag)
  );

  // channel index rides along with its sample
  delay_line #(
    .payload_t (logic [cabs_pkg::COUNT_WIDTH-1:0]),
    .DEPTH     (cabs_pkg::CABS_DELAY)
  ) i_delay_count (
    .clk    (clk),
    .enable (enable),
    .din    (count),
    .dout   (count_out)
  );

  delay_line #(
    .payload_t (logic),
    .DEPTH     (cabs_pkg::CABS_DELAY)
  ) i_delay_last (
    .clk    (clk),
    .enable (enable),
    .din    (last),
    .dout   (last_out)
  );

  // one stage longer, so the beat is still there when the result loads
  delay_line #(
    .payload_t (cabs_pkg::beat_t),
    .DEPTH     (cabs_pkg::CABS_DELAY + 1)
  ) i_delay_data (
    .clk    (clk),
    .enable (enable),
    .din    (s_data),
    .dout   (data_out)
  );

  ////////////////////
  // result gathering

  always_ff @(posedge clk) begin
    if (enable) begin
      mag_gather[count_out] <= mag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      last_out_d   <= 1'b0;
      armed        <= 1'b0;
      result_ready <= 1'b0;
    end else begin
      last_out_d <= last_out;
      if (s_frame) begin
        armed <= 1'b1;
      end
      // last channel just came out of the pipeline
      if (armed && last_out && !last_out_d) begin
        result_ready <= 1'b1;
      end else if (out_free) begin
        result_ready <= 1'b0;
      end
    end
  end

  ////////////////////
  // output register

  assign out_free = ~m_valid | m_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      m_valid <= 1'b0;
    end else if (out_free) begin
      m_valid <= result_ready;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free && result_ready) begin
      m_data.data <= data_out;
      m_data.mag  <= mag_gather;
    end
  end

  a_hold_output: assert property (
    @(posedge clk) disable iff (reset)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_data))
  ) else $error("serializer output changed under back-pressure");

endmodule

`default_nettype wire

// ==== logic/peak_picker.sv ====
// Strongest channel selection
`default_nettype none

module peak_picker (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        s_valid,
  output logic                       s_ready,
  input  wire cabs_pkg::cabs_beat_t  s_data,
  output logic                       m_valid,
  input  wire                        m_ready,
  output cabs_pkg::detect_t          m_data
);

  logic [cabs_pkg::COUNT_WIDTH-1:0] best_idx;
  logic [cabs_pkg::MAG_WIDTH-1:0]   best_mag;

  // strictly larger replaces, so ties keep the lowest index
  always_comb begin
    best_idx = '0;
    best_mag = s_data.mag[0];
    for (int i = 1; i < cabs_pkg::NUM_CHANNELS; i++) begin
      if (s_data.mag[i] > best_mag) begin
        best_idx = i[cabs_pkg::COUNT_WIDTH-1:0];
        best_mag = s_data.mag[i];
      end
    end
  end

  ////////////////////
  // output stage

  assign s_ready = ~m_valid | m_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      m_valid <= 1'b0;
    end else if (s_ready) begin
      m_valid <= s_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s_valid && s_ready) begin
      m_data.data     <= s_data.data;
      m_data.mag      <= s_data.mag;
      m_data.peak_idx <= best_idx;
      m_data.peak_mag <= best_mag;
    end
  end

  a_peak_consistent: assert property (
    @(posedge clk) disable iff (reset)
    m_valid |-> (m_data.peak_mag == m_data.mag[m_data.peak_idx])
  ) else $error("peak magnitude does not match selected channel");

endmodule

`default_nettype wire

// ==== logic/cabs_detector_top.sv ====
// Four-channel magnitude detector
`default_nettype none

module cabs_detector_top (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      s_valid,
  output logic                     s_ready,
  input  wire cabs_pkg::beat_t     s_data,
  output logic                     m_valid,
  input  wire                      m_ready,
  output cabs_pkg::detect_t        m_data
);

  // serializer to peak picker
  logic                  mid_valid;
  logic                  mid_ready;
  cabs_pkg::cabs_beat_t  mid_data;

  cabs_serial i_serial (
    .clk     (clk),
    .reset   (reset),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .m_valid (mid_valid),
    .m_ready (mid_ready),
    .m_data  (mid_data)
  );

  peak_picker i_peak (
    .clk     (clk),
    .reset   (reset),
    .s_valid (mid_valid),
    .s_ready (mid_ready),
    .s_data  (mid_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data)
  );

endmodule

`default_nettype wire

// ==== sim/clock_gen.sv ====
// Testbench clock and reset
`default_nettype none

module clock_gen #(
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== sim/cabs_tb.sv ====
// Magnitude detector testbench
`default_nettype none

module cabs_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_BEATS = 200;
  localparam int RESET_CYCLES = 16;
  // heavy back-pressure stays well under 40 cycles per beat
  localparam int TIMEOUT_CYCLES = NUM_BEATS * 40 + RESET_CYCLES;

  logic              clk;
  logic              reset;
  logic              s_valid;
  logic              s_ready;
  cabs_pkg::beat_t   s_data;
  logic              m_valid;
  logic              m_ready;
  cabs_pkg::detect_t m_data;

  // 0 always ready, 1 mostly ready, 2 rarely ready
  int                ready_mode;
  int                errors;
  int                in_count;
  int                out_count;
  int                cycles;
  cabs_pkg::detect_t expect_q[$];
  cabs_pkg::detect_t head;
  logic              head_valid;

  clock_gen #(.RESET_CYCLES(RESET_CYCLES)) i_clock (.clk(clk), .reset(reset));

  cabs_detector_top i_dut (
    .clk     (clk),
    .reset   (reset),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data)
  );

  ////////////////////
  // reference model

  // larger absolute value plus half the smaller, rounded down
  function automatic int approx_magnitude(cabs_pkg::sample_t s);
    int a;
    int b;
    a = int'(s.re);
    b = int'(s.im);
    if (a < 0) a = -a;
    if (b < 0) b = -b;
    if (a >= b) return a + b / 2;
    return b + a / 2;
  endfunction

  function automatic cabs_pkg::detect_t predict_detect(cabs_pkg::beat_t b);
    cabs_pkg::detect_t d;
    int top;
    d.data = b;
    top = 0;
    for (int i = 0; i < cabs_pkg::NUM_CHANNELS; i++) begin
      d.mag[i] = approx_magnitude(b[i]);
      if (int'(d.mag[i]) > top) top = d.mag[i];
    end
    // walking down leaves the lowest index holding the maximum
    d.peak_idx = '0;
    for (int i = cabs_pkg::NUM_CHANNELS - 1; i >= 0; i--) begin
      if (int'(d.mag[i]) == top) d.peak_idx = i[cabs_pkg::COUNT_WIDTH-1:0];
    end
    d.peak_mag = top;
    return d;
  endfunction

  ////////////////////
  // stimulus helpers

  function automatic logic [15:0] extreme_word();
    case ($urandom % 5)
      0: return 16'h8000;
      1: return 16'h7fff;
      2: return 16'h0000;
      3: return 16'hffff;
      default: return 16'h8001;
    endcase
  endfunction

  function automatic cabs_pkg::beat_t random_beat(bit extremes);
    cabs_pkg::beat_t b;
    for (int ch = 0; ch < cabs_pkg::NUM_CHANNELS; ch++) begin
      if (extremes) b[ch] = {extreme_word(), extreme_word()};
      else b[ch] = {16'($urandom), 16'($urandom)};
    end
    // copies of channel 0 give ties
    if ($urandom % 6 == 0) b[$urandom % cabs_pkg::NUM_CHANNELS] = b[0];
    return b;
  endfunction

  // called on a rising edge, returns on the edge of the transfer
  task automatic send_beat(input cabs_pkg::beat_t b);
    logic taken;
    s_valid <= 1'b1;
    s_data  <= b;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = s_ready;
      @(posedge clk);
    end
  endtask

  task automatic pause(input int n);
    if (n > 0) begin
      s_valid <= 1'b0;
      repeat (n) @(posedge clk);
    end
  endtask

  always @(posedge clk) begin
    case (ready_mode)
      0: m_ready <= 1'b1;
      1: m_ready <= ($urandom % 4) != 0;
      default: m_ready <= ($urandom % 5) == 0;
    endcase
  end

  ////////////////////
  // scoreboard and checks

  always @(posedge clk) begin
    if (reset) begin
      head_valid <= 1'b0;
    end else begin
      if (m_valid && m_ready && expect_q.size() > 0) void'(expect_q.pop_front());
      if (s_valid && s_ready) expect_q.push_back(predict_detect(s_data));
      if (m_valid && m_ready) out_count <= out_count + 1;
      if (s_valid && s_ready) in_count <= in_count + 1;
      head_valid <= expect_q.size() > 0;
      if (expect_q.size() > 0) head <= expect_q[0];
    end
  end

  a_quiet_start: assert property (@(posedge clk) disable iff (reset)
    (in_count == 0) |-> !m_valid)
    else begin
      errors++;
      $display("ERROR %0t m_valid expected 0 actual %0b", $time, $sampled(m_valid));
    end

  a_no_extra: assert property (@(posedge clk) disable iff (reset)
    (m_valid && m_ready) |-> head_valid)
    else begin
      errors++;
      $display("an output beat arrived with no input beat outstanding at %0t", $time);
    end

  a_data: assert property (@(posedge clk) disable iff (reset)
    (m_valid && m_ready && head_valid) |-> (m_data.data == head.data))
    else begin
      errors++;
      $display("ERROR %0t m_data.data expected %h actual %h", $time,
               $sampled(head.data), $sampled(m_data.data));
    end

  a_mag: assert property (@(posedge clk) disable iff (reset)
    (m_valid && m_ready && head_valid) |-> (m_data.mag == head.mag))
    else begin
      errors++;
      $display("ERROR %0t m_data.mag expected %h actual %h", $time,
               $sampled(head.mag), $sampled(m_data.mag));
    end

  a_peak_idx: assert property (@(posedge clk) disable iff (reset)
    (m_valid && m_ready && head_valid) |-> (m_data.peak_idx == head.peak_idx))
    else begin
      errors++;
      $display("ERROR %0t m_data.peak_idx expected %0d actual %0d", $time,
               $sampled(head.peak_idx), $sampled(m_data.peak_idx));
    end

  a_peak_mag: assert property (@(posedge clk) disable iff (reset)
    (m_valid && m_ready && head_valid) |-> (m_data.peak_mag == head.peak_mag))
    else begin
      errors++;
      $display("ERROR %0t m_data.peak_mag expected %0d actual %0d", $time,
               $sampled(head.peak_mag), $sampled(m_data.peak_mag));
    end

  a_hold: assert property (@(posedge clk) disable iff (reset)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_data)))
    else begin
      errors++;
      $display("output beat changed or vanished while stalled at %0t", $time);
    end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d of %0d beats out", cycles, out_count, NUM_BEATS);
      $display("Result: FAILED");
      $finish;
    end
  end

  ////////////////////
  // test sequence

  initial begin
    void'($urandom(32'h7346));
    s_valid = 1'b0;
    s_data = '0;
    m_ready = 1'b0;
    ready_mode = 0;
    @(posedge clk);
    while (reset) @(posedge clk);
    // extreme values and ties, always ready
    repeat (12) send_beat(random_beat(1'b1));
    ready_mode <= 1;
    repeat (60) begin
      send_beat(random_beat(1'b0));
      pause($urandom % 4);
    end
    // long back-pressure
    ready_mode <= 2;
    repeat (60) send_beat(random_beat(($urandom % 4) == 0));
    // full rate on both sides
    ready_mode <= 0;
    repeat (NUM_BEATS - 132) send_beat(random_beat(1'b0));
    // later beats push the last results out of the pipeline
    while (out_count < NUM_BEATS) send_beat(random_beat(1'b0));
    s_valid <= 1'b0;
    @(posedge clk);
    $display("beats in %0d, beats checked %0d, errors %0d", in_count, out_count, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/cabs_pkg.sv
logic/channel_counter.sv
logic/delay_line.sv
logic/cabs_magnitude.sv
logic/cabs_serial.sv
logic/peak_picker.sv
logic/cabs_detector_top.sv
sim/clock_gen.sv
sim/cabs_tb.sv

// ==== Makefile ====
# Verilator build and run for the complex magnitude detector

VERILATOR ?= verilator
TOP       ?= cabs_tb
FILELIST  ?= compile.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Result: PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides pass or fail, not the exit status of the binary
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
